//--- Makefile
# Verilator build and run for the load queue testbench

VERILATOR ?= verilator
TOP       ?= lsu_lq_tb
FILELIST  ?= lsu_lq.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx 'PASS: all tests' $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/lq_pkg.sv
// Load queue structs for allocation, update, fill, store retire, store range, replay and state
package lq_pkg;

`include "lsu_settings.svh"

    // New load issued from the reservation station
    typedef struct packed {
        lsu_op_pkg::lsu_op_e           op;
        logic [`LQ_ROB_IDX_WIDTH-1:0]  tag;
        logic [`LQ_ADDR_WIDTH-1:0]     addr;
    } lq_alloc_t;

    // Result of execute and miss handler lookup for an in-flight load
    typedef struct packed {
        logic                          retry;
        logic                          replay;
        logic [`LQ_MHQ_IDX_WIDTH-1:0]  mhq_tag;
        logic                          mhq_retry;
        logic                          mhq_replay;
    } lq_update_t;

    // Cache line returned by the miss handler
    typedef struct packed {
        logic                          valid;
        logic [`LQ_MHQ_IDX_WIDTH-1:0]  mhq_tag;
    } lq_fill_t;

    // Store leaving the store queue
    typedef struct packed {
        logic                          valid;
        logic [`LQ_ADDR_WIDTH-1:0]     addr;
        lsu_op_pkg::lsu_op_e           op;
    } lq_store_t;

    // Byte range of the retiring store, the end byte is exclusive
    typedef struct packed {
        logic                          valid;
        logic [`LQ_ADDR_WIDTH-1:0]     addr_start;
        logic [`LQ_ADDR_WIDTH-1:0]     addr_end;
    } lq_store_range_t;

    // Load sent back to execute
    typedef struct packed {
        lsu_op_pkg::lsu_op_e           op;
        logic [`LQ_ROB_IDX_WIDTH-1:0]  tag;
        logic [`LQ_ADDR_WIDTH-1:0]     addr;
    } lq_replay_t;

    typedef enum logic [1:0] {
        EMPTY     = 2'd0,
        BUSY      = 2'd1,
        MISS_WAIT = 2'd2,
        REPLAY    = 2'd3
    } lq_state_e;

endpackage

//--- common/lsu_op_pkg.sv
// Memory op encoding, access size type and the op to size function
package lsu_op_pkg;

    localparam int LSU_OP_WIDTH = 4;

    // Loads sit in the lower half of the code space and stores in the upper half
    typedef enum logic [LSU_OP_WIDTH-1:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    // Number of bytes touched by one access
    typedef logic [2:0] lsu_size_t;

    // Word sized ops and anything not recognized count as four bytes
    function automatic lsu_size_t lsu_op_size(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return lsu_size_t'(1);
            LH, LHU, SH: return lsu_size_t'(2);
            default:     return lsu_size_t'(4);
        endcase
    endfunction

endpackage

//--- common/lsu_settings.svh
// Load queue depth and the field widths shared by the load/store unit
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Number of load queue entries
`define LQ_DEPTH 8

// Byte address width of loads and stores
`define LQ_ADDR_WIDTH 32

// Reorder buffer index, used as the load tag
`define LQ_ROB_IDX_WIDTH 5

// Miss handler queue index, used as the fill tag
`define LQ_MHQ_IDX_WIDTH 2

`endif

//--- hw/lsu_lq/lq_dispatch.sv
// Free entry picker, full flag, update steering, store byte range and retire gating
`include "lsu_settings.svh"

module lq_dispatch (
    input  logic                        clk,
    input  logic                        i_rst_n,

    input  logic                        i_alloc_en,
    input  logic                        i_update_en,
    input  logic [`LQ_DEPTH-1:0]        i_update_select,
    input  lq_pkg::lq_store_t           i_store,
    input  logic                        i_rob_retire_en,
    input  logic                        i_sq_nonspec_pending,
    input  logic [`LQ_DEPTH-1:0]        i_entry_empty,

    output logic                        o_full,
    output logic [`LQ_DEPTH-1:0]        o_alloc_select,
    output logic [`LQ_DEPTH-1:0]        o_entry_alloc,
    output logic [`LQ_DEPTH-1:0]        o_entry_update,
    output lq_pkg::lq_store_range_t     o_store_range,
    output logic                        o_retire_en
);

    import lsu_op_pkg::*;
    import lq_pkg::*;

    localparam int ADDR_W = `LQ_ADDR_WIDTH;

    logic [`LQ_DEPTH-1:0] empty_pick;

    // Lowest set bit of the empty vector, x & -x isolates it
    assign empty_pick = i_entry_empty & (~i_entry_empty + `LQ_DEPTH'(1));

    assign o_entry_alloc  = empty_pick & {`LQ_DEPTH{i_alloc_en}};
    assign o_entry_update = i_update_select & {`LQ_DEPTH{i_update_en}};

    // Full as seen after this cycle's allocation lands
    assign o_full = ((i_entry_empty & ~o_entry_alloc) == '0);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_alloc_select <= '0;
        end else begin
            o_alloc_select <= o_entry_alloc;
        end
    end

    // Store range broadcast to every entry for the overlap check
    always_comb begin
        o_store_range.valid      = i_store.valid;
        o_store_range.addr_start = i_store.addr;
        o_store_range.addr_end   = i_store.addr + ADDR_W'(lsu_op_size(i_store.op));
    end

    // Older stores still waiting to write the cache hold back load retirement
    assign o_retire_en = i_rob_retire_en & ~i_sq_nonspec_pending;

endmodule

//--- hw/lsu_lq/lq_entry.sv
// Single load queue slot with state machine, miss wait, store overlap check and retire match
`include "lsu_settings.svh"

module lq_entry (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_flush,

    input  logic                            i_alloc_en,
    input  lq_pkg::lq_alloc_t               i_alloc,
    input  logic                            i_update_en,
    input  lq_pkg::lq_update_t              i_update,
    input  lq_pkg::lq_fill_t                i_fill,
    input  lq_pkg::lq_store_range_t         i_store_range,
    input  logic                            i_replay_grant,
    input  logic                            i_retire_en,
    input  logic [`LQ_ROB_IDX_WIDTH-1:0]    i_retire_tag,

    output logic                            o_empty,
    output logic                            o_replayable,
    output lq_pkg::lq_replay_t              o_replay,
    output logic                            o_retire_match,
    output logic                            o_misspec
);

    import lsu_op_pkg::*;
    import lq_pkg::*;

    localparam int ADDR_W = `LQ_ADDR_WIDTH;

    lq_state_e                      state_q;
    lq_state_e                      state_next;
    lsu_op_e                        op_q;
    logic [`LQ_ROB_IDX_WIDTH-1:0]   tag_q;
    logic [`LQ_ADDR_WIDTH-1:0]      addr_q;
    logic [`LQ_MHQ_IDX_WIDTH-1:0]   mhq_tag_q;
    logic                           misspec_q;

    logic [`LQ_ADDR_WIDTH-1:0]      load_end;
    logic                           fill_hit;
    logic                           store_hit;

    assign o_empty      = (state_q == EMPTY);
    assign o_replayable = (state_q == REPLAY);

    always_comb begin
        o_replay.op   = op_q;
        o_replay.tag  = tag_q;
        o_replay.addr = addr_q;
    end

    assign fill_hit = i_fill.valid & (i_fill.mhq_tag == mhq_tag_q);

    // Two byte ranges overlap when each one starts before the other ends
    assign load_end  = addr_q + ADDR_W'(lsu_op_size(op_q));
    assign store_hit = ~o_empty & i_store_range.valid
                     & (i_store_range.addr_start < load_end)
                     & (addr_q < i_store_range.addr_end);

    assign o_retire_match = i_retire_en & ~o_empty & (tag_q == i_retire_tag);

    // A store that retires in the same cycle as the load still counts
    assign o_misspec = misspec_q | store_hit;

    always_comb begin
        state_next = state_q;
        case (state_q)
            EMPTY: begin
                if (i_alloc_en) begin
                    state_next = BUSY;
                end
            end
            BUSY: begin
                if (i_update_en) begin
                    // Line already filled by the time the miss lookup ran
                    if (i_update.replay || i_update.mhq_replay) begin
                        state_next = REPLAY;
                    end else if (i_update.mhq_retry) begin
                        state_next = MISS_WAIT;
                    end else if (i_update.retry) begin
                        state_next = REPLAY;
                    end else begin
                        state_next = BUSY;
                    end
                end
            end
            MISS_WAIT: begin
                if (fill_hit) begin
                    state_next = REPLAY;
                end
            end
            REPLAY: begin
                if (i_replay_grant) begin
                    state_next = BUSY;
                end
            end
            default: state_next = EMPTY;
        endcase

        if (o_retire_match) begin
            state_next = EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            state_q <= EMPTY;
        end else begin
            state_q <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            op_q   <= i_alloc.op;
            tag_q  <= i_alloc.tag;
            addr_q <= i_alloc.addr;
        end

        if (i_update_en && i_update.mhq_retry) begin
            mhq_tag_q <= i_update.mhq_tag;
        end

        // Sticky until the slot is reused
        if (i_alloc_en) begin
            misspec_q <= 1'b0;
        end else if (store_hit) begin
            misspec_q <= 1'b1;
        end
    end

endmodule

//--- hw/lsu_lq/lq_replay_retire.sv
// Replay picker with stall-held output registers, and the retire acknowledge registers
`include "lsu_settings.svh"

module lq_replay_retire (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_flush,

    input  logic                    i_replay_stall,
    input  logic [`LQ_DEPTH-1:0]    i_replayable,
    input  lq_pkg::lq_replay_t      i_entry_replay [`LQ_DEPTH],
    input  logic [`LQ_DEPTH-1:0]    i_retire_match,
    input  logic [`LQ_DEPTH-1:0]    i_misspec,

    output logic [`LQ_DEPTH-1:0]    o_replay_grant,
    output logic                    o_replay_en,
    output logic [`LQ_DEPTH-1:0]    o_replay_select,
    output lq_pkg::lq_replay_t      o_replay,
    output logic                    o_rob_retire_ack,
    output logic                    o_rob_retire_misspec
);

    import lq_pkg::*;

    logic [`LQ_DEPTH-1:0] replay_pick;
    lq_replay_t           replay_mux;

    // Lowest index replayable entry wins
    assign replay_pick    = i_replayable & (~i_replayable + `LQ_DEPTH'(1));
    assign o_replay_grant = replay_pick & {`LQ_DEPTH{~i_replay_stall}};

    always_comb begin
        replay_mux = '0;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            if (replay_pick[i]) begin
                replay_mux = i_entry_replay[i];
            end
        end
    end

    // Everything holds while execute is stalled, flush still clears the valid
    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            o_replay_en <= 1'b0;
        end else if (!i_replay_stall) begin
            o_replay_en <= |o_replay_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_replay_select <= '0;
        end else if (!i_replay_stall) begin
            o_replay_select <= o_replay_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_replay_stall) begin
            o_replay <= replay_mux;
        end
    end

    // At most one entry matches a retire tag, so an OR reduce picks its misspec bit
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_rob_retire_ack     <= 1'b0;
            o_rob_retire_misspec <= 1'b0;
        end else begin
            o_rob_retire_ack     <= |i_retire_match;
            o_rob_retire_misspec <= |(i_retire_match & i_misspec);
        end
    end

endmodule

//--- hw/lsu_lq/lsu_lq.sv
// Load queue top level with dispatch, the entry array and the replay and retire drain
`include "lsu_settings.svh"

module lsu_lq (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_flush,

    input  logic                            i_alloc_en,
    input  lq_pkg::lq_alloc_t               i_alloc,
    output logic                            o_full,
    output logic [`LQ_DEPTH-1:0]            o_alloc_select,

    input  logic                            i_update_en,
    input  logic [`LQ_DEPTH-1:0]            i_update_select,
    input  lq_pkg::lq_update_t              i_update,

    input  lq_pkg::lq_fill_t                i_fill,
    input  lq_pkg::lq_store_t               i_store,

    input  logic                            i_rob_retire_en,
    input  logic [`LQ_ROB_IDX_WIDTH-1:0]    i_rob_retire_tag,
    input  logic                            i_sq_nonspec_pending,
    output logic                            o_rob_retire_ack,
    output logic                            o_rob_retire_misspec,

    input  logic                            i_replay_stall,
    output logic                            o_replay_en,
    output logic [`LQ_DEPTH-1:0]            o_replay_select,
    output lq_pkg::lq_replay_t              o_replay
);

    import lq_pkg::*;

    logic [`LQ_DEPTH-1:0] entry_alloc;
    logic [`LQ_DEPTH-1:0] entry_update;
    logic [`LQ_DEPTH-1:0] entry_empty;
    logic [`LQ_DEPTH-1:0] entry_replayable;
    logic [`LQ_DEPTH-1:0] entry_retire_match;
    logic [`LQ_DEPTH-1:0] entry_misspec;
    logic [`LQ_DEPTH-1:0] replay_grant;
    lq_replay_t           entry_replay [`LQ_DEPTH];
    lq_store_range_t      store_range;
    logic                 retire_en;

    lq_dispatch u_dispatch (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_alloc_en           (i_alloc_en),
        .i_update_en          (i_update_en),
        .i_update_select      (i_update_select),
        .i_store              (i_store),
        .i_rob_retire_en      (i_rob_retire_en),
        .i_sq_nonspec_pending (i_sq_nonspec_pending),
        .i_entry_empty        (entry_empty),
        .o_full               (o_full),
        .o_alloc_select       (o_alloc_select),
        .o_entry_alloc        (entry_alloc),
        .o_entry_update       (entry_update),
        .o_store_range        (store_range),
        .o_retire_en          (retire_en)
    );

    for (genvar i = 0; i < `LQ_DEPTH; i++) begin : g_entry
        lq_entry u_entry (
            .clk            (clk),
            .i_rst_n        (i_rst_n),
            .i_flush        (i_flush),
            .i_alloc_en     (entry_alloc[i]),
            .i_alloc        (i_alloc),
            .i_update_en    (entry_update[i]),
            .i_update       (i_update),
            .i_fill         (i_fill),
            .i_store_range  (store_range),
            .i_replay_grant (replay_grant[i]),
            .i_retire_en    (retire_en),
            .i_retire_tag   (i_rob_retire_tag),
            .o_empty        (entry_empty[i]),
            .o_replayable   (entry_replayable[i]),
            .o_replay       (entry_replay[i]),
            .o_retire_match (entry_retire_match[i]),
            .o_misspec      (entry_misspec[i])
        );
    end

    lq_replay_retire u_replay_retire (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_flush              (i_flush),
        .i_replay_stall       (i_replay_stall),
        .i_replayable         (entry_replayable),
        .i_entry_replay       (entry_replay),
        .i_retire_match       (entry_retire_match),
        .i_misspec            (entry_misspec),
        .o_replay_grant       (replay_grant),
        .o_replay_en          (o_replay_en),
        .o_replay_select      (o_replay_select),
        .o_replay             (o_replay),
        .o_rob_retire_ack     (o_rob_retire_ack),
        .o_rob_retire_misspec (o_rob_retire_misspec)
    );

endmodule

//--- lsu_lq.f
+incdir+common
common/lsu_op_pkg.sv
common/lq_pkg.sv
hw/lsu_lq/lq_dispatch.sv
hw/lsu_lq/lq_entry.sv
hw/lsu_lq/lq_replay_retire.sv
hw/lsu_lq/lsu_lq.sv
tb/lsu_lq_tb.sv

//--- tb/lsu_lq_tb.sv
// Directed testbench for the load queue with clock, reset, watchdog, stimulus and compare tasks
`include "lsu_settings.svh"

module lsu_lq_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import lsu_op_pkg::*;
    import lq_pkg::*;

    localparam int AW    = `LQ_ADDR_WIDTH;
    localparam int TW    = `LQ_ROB_IDX_WIDTH;
    localparam int DEPTH = `LQ_DEPTH;

    // The tests need a few hundred cycles at most, this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                 clk;
    logic                 i_rst_n;
    logic                 i_flush;
    logic                 i_alloc_en;
    lq_alloc_t            i_alloc;
    logic                 o_full;
    logic [DEPTH-1:0]     o_alloc_select;
    logic                 i_update_en;
    logic [DEPTH-1:0]     i_update_select;
    lq_update_t           i_update;
    lq_fill_t             i_fill;
    lq_store_t            i_store;
    logic                 i_rob_retire_en;
    logic [TW-1:0]        i_rob_retire_tag;
    logic                 i_sq_nonspec_pending;
    logic                 o_rob_retire_ack;
    logic                 o_rob_retire_misspec;
    logic                 i_replay_stall;
    logic                 o_replay_en;
    logic [DEPTH-1:0]     o_replay_select;
    lq_replay_t           o_replay;

    string                cur_test;
    int                   test_errs   = 0;
    int                   err_count   = 0;
    int                   test_count  = 0;
    int                   fail_count  = 0;
    int                   cycle_count = 0;
    logic [AW-1:0]        addr_base;
    logic [TW-1:0]        tag_base;

    lsu_lq UUT (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_flush              (i_flush),
        .i_alloc_en           (i_alloc_en),
        .i_alloc              (i_alloc),
        .o_full               (o_full),
        .o_alloc_select       (o_alloc_select),
        .i_update_en          (i_update_en),
        .i_update_select      (i_update_select),
        .i_update             (i_update),
        .i_fill               (i_fill),
        .i_store              (i_store),
        .i_rob_retire_en      (i_rob_retire_en),
        .i_rob_retire_tag     (i_rob_retire_tag),
        .i_sq_nonspec_pending (i_sq_nonspec_pending),
        .o_rob_retire_ack     (o_rob_retire_ack),
        .o_rob_retire_misspec (o_rob_retire_misspec),
        .i_replay_stall       (i_replay_stall),
        .o_replay_en          (o_replay_en),
        .o_replay_select      (o_replay_select),
        .o_replay             (o_replay)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles before the tests completed", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [DEPTH-1:0] onehot(input int idx);
        return DEPTH'(1) << idx;
    endfunction

    // Entries sit 16 bytes apart so that a store hits at most one of them
    function automatic logic [AW-1:0] load_addr(input int idx);
        return addr_base + AW'(16 * idx);
    endfunction

    function automatic logic [TW-1:0] load_tag(input int idx);
        return tag_base + TW'(idx);
    endfunction

    function automatic lq_replay_t make_replay(input lsu_op_e op, input logic [TW-1:0] tag,
                                               input logic [AW-1:0] addr);
        lq_replay_t r;
        r.op   = op;
        r.tag  = tag;
        r.addr = addr;
        return r;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic idle_inputs();
        i_flush              = 1'b0;
        i_alloc_en           = 1'b0;
        i_alloc              = '0;
        i_update_en          = 1'b0;
        i_update_select      = '0;
        i_update             = '0;
        i_fill               = '0;
        i_store              = '0;
        i_rob_retire_en      = 1'b0;
        i_rob_retire_tag     = '0;
        i_sq_nonspec_pending = 1'b0;
        i_replay_stall       = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        test_count++;
        if (test_errs == 0) begin
            $display("%s: passed", cur_test);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic compare_replay(input string what, input lq_replay_t exp,
                                  input lq_replay_t act);
        if (act !== exp) begin
            $display("ERR %s: %s expected op=%h tag=%h addr=%h, actual op=%h tag=%h addr=%h",
                     cur_test, what, exp.op, exp.tag, exp.addr, act.op, act.tag, act.addr);
            test_errs++;
            err_count++;
        end
    endtask

    task automatic verify_select(input string what, input logic [DEPTH-1:0] exp,
                                 input logic [DEPTH-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: %s expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
            err_count++;
        end
    endtask

    task automatic expect_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: %s expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
            err_count++;
        end
    endtask

    task automatic clear_queue();
        i_flush = 1'b1;
        next_cycle();
        i_flush = 1'b0;
        next_cycle();
    endtask

    task automatic drive_alloc(input lsu_op_e op, input logic [TW-1:0] tag,
                               input logic [AW-1:0] addr);
        i_alloc_en   = 1'b1;
        i_alloc.op   = op;
        i_alloc.tag  = tag;
        i_alloc.addr = addr;
    endtask

    task automatic alloc_load(input lsu_op_e op, input logic [TW-1:0] tag,
                              input logic [AW-1:0] addr, input int slot);
        drive_alloc(op, tag, addr);
        next_cycle();
        i_alloc_en = 1'b0;
        verify_select("alloc select", onehot(slot), o_alloc_select);
    endtask

    task automatic update_entry(input int slot, input logic replay, input logic mhq_retry,
                                input logic [`LQ_MHQ_IDX_WIDTH-1:0] mhq_tag);
        i_update_en          = 1'b1;
        i_update_select      = onehot(slot);
        i_update             = '0;
        i_update.replay      = replay;
        i_update.mhq_retry   = mhq_retry;
        i_update.mhq_tag     = mhq_tag;
        next_cycle();
        i_update_en     = 1'b0;
        i_update_select = '0;
    endtask

    task automatic send_fill(input logic [`LQ_MHQ_IDX_WIDTH-1:0] mhq_tag);
        i_fill.valid   = 1'b1;
        i_fill.mhq_tag = mhq_tag;
        next_cycle();
        i_fill = '0;
    endtask

    task automatic send_store(input logic [AW-1:0] addr, input lsu_op_e op);
        i_store.valid = 1'b1;
        i_store.addr  = addr;
        i_store.op    = op;
        next_cycle();
        i_store = '0;
    endtask

    task automatic retire_load(input logic [TW-1:0] tag, input logic exp_misspec);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        next_cycle();
        i_rob_retire_en = 1'b0;
        expect_bit("retire ack", 1'b1, o_rob_retire_ack);
        expect_bit("retire misspec", exp_misspec, o_rob_retire_misspec);
    endtask

    task automatic reset_state();
        begin_test("reset_state");
        expect_bit("replay valid", 1'b0, o_replay_en);
        expect_bit("retire ack", 1'b0, o_rob_retire_ack);
        expect_bit("full", 1'b0, o_full);
        verify_select("alloc select", '0, o_alloc_select);
        report_test();
    endtask

    task automatic fill_order_and_full();
        begin_test("fill_order_and_full");
        clear_queue();
        for (int i = 0; i < DEPTH; i++) begin
            drive_alloc(LW, load_tag(i), load_addr(i));
            #1;
            expect_bit("full in allocation cycle", (i == DEPTH - 1), o_full);
            next_cycle();
            verify_select("alloc select", onehot(i), o_alloc_select);
        end
        i_alloc_en = 1'b0;
        next_cycle();
        verify_select("alloc select when idle", '0, o_alloc_select);
        expect_bit("full with every entry held", 1'b1, o_full);
        report_test();
    endtask

    task automatic replay_after_miss();
        begin_test("replay_after_miss");
        clear_queue();
        alloc_load(LW, load_tag(0), load_addr(0), 0);
        alloc_load(LH, load_tag(1), load_addr(1), 1);
        update_entry(1, 1'b0, 1'b1, 2'd2);
        update_entry(0, 1'b0, 1'b1, 2'd1);
        send_fill(2'd3);
        next_cycle();
        expect_bit("replay on unrelated fill", 1'b0, o_replay_en);
        send_fill(2'd2);
        next_cycle();
        expect_bit("replay valid", 1'b1, o_replay_en);
        verify_select("replay select", onehot(1), o_replay_select);
        compare_replay("replay fields", make_replay(LH, load_tag(1), load_addr(1)), o_replay);
        // Park entry 1 again on the tag entry 0 waits for, one fill wakes both
        update_entry(1, 1'b0, 1'b1, 2'd1);
        send_fill(2'd1);
        next_cycle();
        verify_select("first of two", onehot(0), o_replay_select);
        compare_replay("first of two", make_replay(LW, load_tag(0), load_addr(0)), o_replay);
        next_cycle();
        verify_select("second of two", onehot(1), o_replay_select);
        compare_replay("second of two", make_replay(LH, load_tag(1), load_addr(1)), o_replay);
        next_cycle();
        expect_bit("replay valid when drained", 1'b0, o_replay_en);
        report_test();
    endtask

    task automatic replay_under_stall();
        lq_replay_t first;
        lq_replay_t second;
        begin_test("replay_under_stall");
        first  = make_replay(LW, load_tag(2), load_addr(2));
        second = make_replay(LBU, load_tag(3), load_addr(3));
        clear_queue();
        alloc_load(LW, load_tag(2), load_addr(2), 0);
        alloc_load(LBU, load_tag(3), load_addr(3), 1);
        update_entry(0, 1'b1, 1'b0, '0);
        update_entry(1, 1'b1, 1'b0, '0);
        compare_replay("before stall", first, o_replay);
        i_replay_stall = 1'b1;
        repeat (3) begin
            next_cycle();
            expect_bit("valid held in stall", 1'b1, o_replay_en);
            verify_select("select held in stall", onehot(0), o_replay_select);
            compare_replay("fields held in stall", first, o_replay);
        end
        i_replay_stall = 1'b0;
        next_cycle();
        verify_select("after release", onehot(1), o_replay_select);
        compare_replay("after release", second, o_replay);
        next_cycle();
        expect_bit("replay valid when drained", 1'b0, o_replay_en);
        report_test();
    endtask

    task automatic retire_and_misspec();
        begin_test("retire_and_misspec");
        clear_queue();
        for (int i = 0; i < 3; i++) begin
            alloc_load(LW, load_tag(i), load_addr(i), i);
        end
        retire_load(load_tag(0), 1'b0);
        // The freed slot is the lowest empty one again
        alloc_load(LW, load_tag(3), load_addr(0), 0);
        // One SB lands inside the word of entry 1, the other just past the word of entry 2
        send_store(load_addr(1) + 32'd2, SB);
        send_store(load_addr(2) + 32'd4, SB);
        retire_load(load_tag(1), 1'b1);
        retire_load(load_tag(2), 1'b0);
        retire_load(load_tag(3), 1'b0);
        report_test();
    endtask

    task automatic retire_blocking();
        begin_test("retire_blocking");
        clear_queue();
        alloc_load(LW, load_tag(4), load_addr(4), 0);
        i_sq_nonspec_pending = 1'b1;
        i_rob_retire_en      = 1'b1;
        i_rob_retire_tag     = load_tag(4);
        repeat (3) begin
            next_cycle();
            expect_bit("ack while store pending", 1'b0, o_rob_retire_ack);
        end
        i_sq_nonspec_pending = 1'b0;
        next_cycle();
        i_rob_retire_en = 1'b0;
        expect_bit("ack after release", 1'b1, o_rob_retire_ack);
        expect_bit("misspec after release", 1'b0, o_rob_retire_misspec);
        next_cycle();
        expect_bit("ack once only", 1'b0, o_rob_retire_ack);
        report_test();
    endtask

    task automatic flush_empties();
        begin_test("flush_empties");
        clear_queue();
        for (int i = 0; i < DEPTH; i++) begin
            alloc_load(LW, load_tag(i), load_addr(i), i);
        end
        #1;
        expect_bit("full before flush", 1'b1, o_full);
        update_entry(3, 1'b1, 1'b0, '0);
        next_cycle();
        expect_bit("replay before flush", 1'b1, o_replay_en);
        // The stall would hold the replay valid, so only the flush can clear it
        i_replay_stall = 1'b1;
        i_flush        = 1'b1;
        next_cycle();
        i_flush        = 1'b0;
        i_replay_stall = 1'b0;
        #1;
        expect_bit("replay valid after flush", 1'b0, o_replay_en);
        expect_bit("full after flush", 1'b0, o_full);
        next_cycle();
        alloc_load(LW, load_tag(8), load_addr(0), 0);
        report_test();
    endtask

    initial begin
        void'($urandom(32'h8e7e_0c15));
        idle_inputs();
        i_rst_n   = 1'b0;
        addr_base = $urandom() & 32'h7fff_ff00;
        tag_base  = TW'($urandom());
        repeat (10) @(negedge clk);
        i_rst_n = 1'b1;

        reset_state();
        fill_order_and_full();
        replay_after_miss();
        replay_under_stall();
        retire_and_misspec();
        retire_blocking();
        flush_empties();

        $display("Tests run %0d, failed %0d, check errors %0d", test_count, fail_count, err_count);
        if (fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
